//--- hdl/rx_axil_regs.sv
// AXI4-Lite register block on baud_clk, one outstanding transfer per direction.
// Only byte lane 0 of a write is used.
module rx_axil_regs #(
  parameter int DEPTH = 8
) (
  input  logic                   baud_clk,
  input  logic                   reset_n,
  input  logic                   awvalid,
  output logic                   awready,
  input  uart_rx_pkg::axil_aw_t  aw,
  input  logic                   wvalid,
  output logic                   wready,
  input  uart_rx_pkg::axil_w_t   w,
  output logic                   bvalid,
  input  logic                   bready,
  output uart_rx_pkg::axil_b_t   b,
  input  logic                   arvalid,
  output logic                   arready,
  input  uart_rx_pkg::axil_ar_t  ar,
  output logic                   rvalid,
  input  logic                   rready,
  output uart_rx_pkg::axil_r_t   r,
  input  uart_rx_pkg::rx_byte_t  head,
  input  logic                   empty,
  input  logic [$clog2(DEPTH):0] level,
  input  logic                   overrun_pulse,
  output logic                   pop,
  output uart_rx_pkg::parity_e   parity_mode,
  output logic                   rx_enable
);

  localparam int LVL_W = $clog2(DEPTH) + 1;

  uart_rx_pkg::reg_addr_e wr_addr;
  uart_rx_pkg::reg_addr_e rd_addr;
  uart_rx_pkg::axi_resp_e wr_resp;
  uart_rx_pkg::axi_resp_e rd_resp;
  logic [31:0]            rd_data;
  logic                   wr_hs;
  logic                   rd_hs;
  logic                   overrun;
  logic                   clr_overrun;
  logic                   ctrl_wr;

  assign wr_addr = uart_rx_pkg::reg_addr_e'(aw.addr);
  assign rd_addr = uart_rx_pkg::reg_addr_e'(ar.addr);

  // AW and W accepted together, blocked while B is pending
  assign awready = awvalid && wvalid && !bvalid;
  assign wready  = awready;
  assign wr_hs   = awready;
  assign arready = arvalid && !rvalid;
  assign rd_hs   = arready;

  // DATA read takes the head word on the AR transfer
  assign pop = rd_hs && (rd_addr == uart_rx_pkg::REG_DATA) && !empty;

  // Write decode
  always_comb
  begin
    wr_resp     = uart_rx_pkg::RESP_SLVERR;
    clr_overrun = 1'b0;
    ctrl_wr     = 1'b0;
    case (wr_addr)
      uart_rx_pkg::REG_STATUS:
      begin
        wr_resp     = uart_rx_pkg::RESP_OKAY;
        // Write 1 to clear
        clr_overrun = wr_hs && w.strb[0] && w.data[1];
      end
      uart_rx_pkg::REG_CTRL:
      begin
        wr_resp = uart_rx_pkg::RESP_OKAY;
        ctrl_wr = wr_hs && w.strb[0];
      end
      default:
        wr_resp = uart_rx_pkg::RESP_SLVERR;
    endcase
  end

  // Read decode
  always_comb
  begin
    rd_data = '0;
    rd_resp = uart_rx_pkg::RESP_OKAY;
    case (rd_addr)
      uart_rx_pkg::REG_DATA:
      begin
        // Bit 31 marks an empty FIFO
        if (empty)
          rd_data[31] = 1'b1;
        else
          rd_data[9:0] = head;
      end
      uart_rx_pkg::REG_STATUS:
      begin
        rd_data[0]           = empty;
        rd_data[1]           = overrun;
        rd_data[8 +: LVL_W]  = level;
      end
      uart_rx_pkg::REG_CTRL:
      begin
        rd_data[0] = (parity_mode == uart_rx_pkg::PAR_ODD);
        rd_data[1] = rx_enable;
      end
      default:
        rd_resp = uart_rx_pkg::RESP_SLVERR;
    endcase
  end

  // Control registers and handshake state
  always_ff @(posedge baud_clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      bvalid      <= 1'b0;
      rvalid      <= 1'b0;
      overrun     <= 1'b0;
      parity_mode <= uart_rx_pkg::PAR_EVEN;
      rx_enable   <= 1'b1;
    end
    else
    begin
      if (wr_hs)
        bvalid <= 1'b1;
      else if (bready)
        bvalid <= 1'b0;
      if (rd_hs)
        rvalid <= 1'b1;
      else if (rready)
        rvalid <= 1'b0;
      // A new overrun wins over a clear in the same cycle
      if (overrun_pulse)
        overrun <= 1'b1;
      else if (clr_overrun)
        overrun <= 1'b0;
      if (ctrl_wr)
      begin
        parity_mode <= uart_rx_pkg::parity_e'(w.data[0]);
        rx_enable   <= w.data[1];
      end
    end
  end

  // Response payloads
  always_ff @(posedge baud_clk)
  begin
    if (wr_hs)
      b.resp <= wr_resp;
    if (rd_hs)
    begin
      r.data <= rd_data;
      r.resp <= rd_resp;
    end
  end

  a_bvalid_hold: assert property (
    @(posedge baud_clk) disable iff (!reset_n)
    bvalid && !bready |=> bvalid
  );

endmodule

//--- hdl/rx_deframe.sv
// Frame checker with one cycle of latency.
// Parity mode is sampled on the cycle the frame arrives.
module rx_deframe (
  input  logic                   baud_clk,
  input  logic                   reset_n,
  input  uart_rx_pkg::rx_frame_t frame,
  input  logic                   frame_valid,
  input  uart_rx_pkg::parity_e   parity_mode,
  output uart_rx_pkg::rx_byte_t  byte_out,
  output logic                   byte_valid
);

  logic par_sum;
  logic frame_bad;
  logic par_bad;

  // Even parity expects the XOR over data and parity to be 0
  assign par_sum   = ^{frame.data, frame.parity};
  assign par_bad   = (parity_mode == uart_rx_pkg::PAR_ODD) ? !par_sum : par_sum;
  // Start must be 0 and stop must be 1
  assign frame_bad = frame.start || !frame.stop;

  always_ff @(posedge baud_clk or negedge reset_n)
  begin
    if (!reset_n)
      byte_valid <= 1'b0;
    else
      byte_valid <= frame_valid;
  end

  // Payload, captured only with a new frame
  always_ff @(posedge baud_clk)
  begin
    if (frame_valid)
    begin
      byte_out.data       <= frame.data;
      byte_out.frame_err  <= frame_bad;
      byte_out.parity_err <= par_bad;
    end
  end

  // A frame yields its byte on the next cycle
  a_byte_follows_frame: assert property (
    @(posedge baud_clk) disable iff (!reset_n)
    frame_valid |=> byte_valid && (byte_out.data == $past(frame.data)) &&
                    (byte_out.parity_err ==
                     ^{$past(frame.data), $past(frame.parity),
                       $past(parity_mode == uart_rx_pkg::PAR_ODD)})
  );

endmodule

//--- hdl/rx_fifo.sv
// Show-ahead FIFO for received bytes. DEPTH must be a power of two.
// A push while full is dropped and flagged on overrun_pulse.
module rx_fifo #(
  parameter int DEPTH = 8
) (
  input  logic                  baud_clk,
  input  logic                  reset_n,
  input  logic                  push,
  input  uart_rx_pkg::rx_byte_t din,
  input  logic                  pop,
  output uart_rx_pkg::rx_byte_t head,
  output logic                  empty,
  output logic [$clog2(DEPTH):0] level,
  output logic                  overrun_pulse
);

  localparam int AW = $clog2(DEPTH);

  uart_rx_pkg::rx_byte_t mem [DEPTH];
  logic [AW-1:0]         wr_ptr;
  logic [AW-1:0]         rd_ptr;
  logic [AW:0]           count;
  logic                  full;
  logic                  do_push;
  logic                  do_pop;

  assign full    = (count == (AW + 1)'(DEPTH));
  assign empty   = (count == '0);
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  // Storage, pointers wrap on their own width
  always_ff @(posedge baud_clk)
  begin
    if (do_push)
      mem[wr_ptr] <= din;
  end

  always_ff @(posedge baud_clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      overrun_pulse <= 1'b0;
    end
    else
    begin
      overrun_pulse <= push && full;
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Head visible without read latency
  assign head  = mem[rd_ptr];
  assign level = count;

  // Register block only pops a non-empty FIFO
  a_no_pop_empty: assert property (
    @(posedge baud_clk) disable iff (!reset_n)
    pop |-> !empty
  );

endmodule

//--- hdl/rx_sipo.sv
// Serial input stage, runs on the 16x oversampling clock.
// Only the start of a frame is gated by enable; a frame in flight completes.
module rx_sipo (
  input  logic                   baud_clk,
  input  logic                   reset_n,
  input  logic                   rx,
  input  logic                   enable,
  output uart_rx_pkg::rx_frame_t frame,
  output logic                   frame_valid
);

  localparam int CNT_W = $clog2(uart_rx_pkg::OVERSAMPLE);
  localparam int BIT_W = $clog2(uart_rx_pkg::FRAME_BITS);

  logic [1:0]                          rx_sync;
  logic                                rx_s;
  uart_rx_pkg::rx_state_e              state;
  logic [CNT_W-1:0]                    sample_cnt;
  logic [BIT_W-1:0]                    bit_cnt;
  logic [uart_rx_pkg::FRAME_BITS-1:0]  shreg;
  logic                                center_hit;
  logic                                bit_hit;
  logic                                last_bit;

  // Two-flop synchronizer, line idles high
  always_ff @(posedge baud_clk or negedge reset_n)
  begin
    if (!reset_n)
      rx_sync <= 2'b11;
    else
      rx_sync <= {rx_sync[0], rx};
  end

  assign rx_s = rx_sync[1];

  // Start bit centre reached
  assign center_hit = (state == uart_rx_pkg::CENTER) &&
                      (sample_cnt == CNT_W'(uart_rx_pkg::HALF_BIT - 1));
  // Centre of a data, parity or stop bit
  assign bit_hit    = (state == uart_rx_pkg::FRAME) &&
                      (sample_cnt == CNT_W'(uart_rx_pkg::OVERSAMPLE - 1));
  // Ten bits follow the start bit
  assign last_bit   = (bit_cnt == BIT_W'(uart_rx_pkg::FRAME_BITS - 2));

  always_ff @(posedge baud_clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state       <= uart_rx_pkg::IDLE;
      sample_cnt  <= '0;
      bit_cnt     <= '0;
      frame_valid <= 1'b0;
    end
    else
    begin
      frame_valid <= 1'b0;
      case (state)
        uart_rx_pkg::IDLE:
        begin
          sample_cnt <= '0;
          bit_cnt    <= '0;
          // Falling edge seen as low level after the synchronizer
          if (enable && !rx_s)
            state <= uart_rx_pkg::CENTER;
        end
        uart_rx_pkg::CENTER:
        begin
          if (center_hit)
          begin
            sample_cnt <= '0;
            // Line back high at centre, so it was a glitch
            if (rx_s)
              state <= uart_rx_pkg::IDLE;
            else
              state <= uart_rx_pkg::FRAME;
          end
          else
            sample_cnt <= sample_cnt + 1'b1;
        end
        uart_rx_pkg::FRAME:
        begin
          if (bit_hit)
          begin
            sample_cnt <= '0;
            bit_cnt    <= bit_cnt + 1'b1;
            // Stop bit taken, report the frame next cycle
            if (last_bit)
            begin
              frame_valid <= 1'b1;
              state       <= uart_rx_pkg::IDLE;
            end
          end
          else
            sample_cnt <= sample_cnt + 1'b1;
        end
        default:
          state <= uart_rx_pkg::IDLE;
      endcase
    end
  end

  // LSB first, so each new bit enters at the top and moves down
  always_ff @(posedge baud_clk)
  begin
    if (center_hit || bit_hit)
      shreg <= {rx_s, shreg[uart_rx_pkg::FRAME_BITS-1:1]};
  end

  assign frame = uart_rx_pkg::rx_frame_t'(shreg);

  // One frame per event, never back to back
  a_frame_valid_pulse: assert property (
    @(posedge baud_clk) disable iff (!reset_n)
    frame_valid |=> !frame_valid
  );

endmodule

//--- hdl/uart_rx_pkg.sv
// Shared types for the UART receiver. The frame is fixed at 8 data bits,
// one parity bit and one stop bit, sampled at 16x oversampling.
package uart_rx_pkg;

  // Oversampling and frame geometry
  localparam int OVERSAMPLE = 16;
  localparam int HALF_BIT   = 8;
  localparam int FRAME_BITS = 11;

  // Receiver FSM states
  typedef enum logic [1:0] {
    IDLE,
    CENTER,
    FRAME
  } rx_state_e;

  typedef enum logic {
    PAR_EVEN = 1'b0,
    PAR_ODD  = 1'b1
  } parity_e;

  // Raw frame, start bit in the LSB as it arrives first
  typedef struct packed {
    logic       stop;
    logic       parity;
    logic [7:0] data;
    logic       start;
  } rx_frame_t;

  // Checked byte as stored in the FIFO
  typedef struct packed {
    logic       frame_err;
    logic       parity_err;
    logic [7:0] data;
  } rx_byte_t;

  // Register map
  typedef enum logic [3:0] {
    REG_DATA   = 4'h0,
    REG_STATUS = 4'h4,
    REG_CTRL   = 4'h8
  } reg_addr_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_e;

  // AXI4-Lite channel payloads
  typedef struct packed {
    logic [3:0] addr;
  } axil_aw_t;

  typedef struct packed {
    logic [31:0] data;
    logic [3:0]  strb;
  } axil_w_t;

  typedef struct packed {
    logic [3:0] addr;
  } axil_ar_t;

  typedef struct packed {
    logic [31:0] data;
    axi_resp_e   resp;
  } axil_r_t;

  typedef struct packed {
    axi_resp_e resp;
  } axil_b_t;

endpackage

//--- hdl/uart_rx_top.sv
// UART receiver with AXI4-Lite access, all on the 16x baud clock.
// FIFO_DEPTH must be a power of two.
module uart_rx_top #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic                  baud_clk,
  input  logic                  reset_n,
  input  logic                  rx,
  input  logic                  awvalid,
  output logic                  awready,
  input  uart_rx_pkg::axil_aw_t aw,
  input  logic                  wvalid,
  output logic                  wready,
  input  uart_rx_pkg::axil_w_t  w,
  output logic                  bvalid,
  input  logic                  bready,
  output uart_rx_pkg::axil_b_t  b,
  input  logic                  arvalid,
  output logic                  arready,
  input  uart_rx_pkg::axil_ar_t ar,
  output logic                  rvalid,
  input  logic                  rready,
  output uart_rx_pkg::axil_r_t  r
);

  uart_rx_pkg::rx_frame_t       frame;
  logic                         frame_valid;
  uart_rx_pkg::rx_byte_t        byte_out;
  logic                         byte_valid;
  uart_rx_pkg::rx_byte_t        head;
  logic                         empty;
  logic [$clog2(FIFO_DEPTH):0]  level;
  logic                         overrun_pulse;
  logic                         pop;
  uart_rx_pkg::parity_e         parity_mode;
  logic                         rx_enable;

  // Serial line to raw frame
  rx_sipo rx_sipo_i (
    .baud_clk    (baud_clk),
    .reset_n     (reset_n),
    .rx          (rx),
    .enable      (rx_enable),
    .frame       (frame),
    .frame_valid (frame_valid)
  );

  rx_deframe rx_deframe_i (
    .baud_clk    (baud_clk),
    .reset_n     (reset_n),
    .frame       (frame),
    .frame_valid (frame_valid),
    .parity_mode (parity_mode),
    .byte_out    (byte_out),
    .byte_valid  (byte_valid)
  );

  rx_fifo #(
    .DEPTH (FIFO_DEPTH)
  ) rx_fifo_i (
    .baud_clk      (baud_clk),
    .reset_n       (reset_n),
    .push          (byte_valid),
    .din           (byte_out),
    .pop           (pop),
    .head          (head),
    .empty         (empty),
    .level         (level),
    .overrun_pulse (overrun_pulse)
  );

  // CPU side
  rx_axil_regs #(
    .DEPTH (FIFO_DEPTH)
  ) rx_axil_regs_i (
    .baud_clk      (baud_clk),
    .reset_n       (reset_n),
    .awvalid       (awvalid),
    .awready       (awready),
    .aw            (aw),
    .wvalid        (wvalid),
    .wready        (wready),
    .w             (w),
    .bvalid        (bvalid),
    .bready        (bready),
    .b             (b),
    .arvalid       (arvalid),
    .arready       (arready),
    .ar            (ar),
    .rvalid        (rvalid),
    .rready        (rready),
    .r             (r),
    .head          (head),
    .empty         (empty),
    .level         (level),
    .overrun_pulse (overrun_pulse),
    .pop           (pop),
    .parity_mode   (parity_mode),
    .rx_enable     (rx_enable)
  );

endmodule

//--- testbench/uart_rx_tb.sv
// Testbench for uart_rx_top with FIFO depth 8. Serial frames use 16 clocks per bit.
// bready and rready are held high, so B and R responses never stall.
module uart_rx_tb;

  localparam int DEPTH       = 8;
  localparam int CYCLE_LIMIT = 60 * uart_rx_pkg::FRAME_BITS * uart_rx_pkg::OVERSAMPLE * 12 / 10;

  logic                  baud_clk;
  logic                  reset_n;
  logic                  rx;
  logic                  awvalid;
  logic                  awready;
  uart_rx_pkg::axil_aw_t aw;
  logic                  wvalid;
  logic                  wready;
  uart_rx_pkg::axil_w_t  w;
  logic                  bvalid;
  logic                  bready;
  uart_rx_pkg::axil_b_t  b;
  logic                  arvalid;
  logic                  arready;
  uart_rx_pkg::axil_ar_t ar;
  logic                  rvalid;
  logic                  rready;
  uart_rx_pkg::axil_r_t  r;

  // Reference model state
  uart_rx_pkg::rx_byte_t exp_q [$];
  logic                  exp_overrun;
  logic                  par_odd;
  logic                  rx_on;
  integer                seed;
  int                    errors;
  int                    cycle_cnt;

  uart_rx_top #(
    .FIFO_DEPTH (DEPTH)
  ) uart_rx_top_i (
    .baud_clk (baud_clk),
    .reset_n  (reset_n),
    .rx       (rx),
    .awvalid  (awvalid),
    .awready  (awready),
    .aw       (aw),
    .wvalid   (wvalid),
    .wready   (wready),
    .w        (w),
    .bvalid   (bvalid),
    .bready   (bready),
    .b        (b),
    .arvalid  (arvalid),
    .arready  (arready),
    .ar       (ar),
    .rvalid   (rvalid),
    .rready   (rready),
    .r        (r)
  );

  always #20 baud_clk = ~baud_clk;

  // Watchdog sized for 60 frames plus margin
  always @(posedge baud_clk)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT)
    begin
      $display("Test timed out after %0d cycles with %0d errors", cycle_cnt, errors);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
    begin
      errors = errors + 1;
      $display("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // One serial bit, held for a full bit period
  task automatic drive_bit(input logic val);
    @(posedge baud_clk);
    #2;
    rx = val;
    repeat (uart_rx_pkg::OVERSAMPLE - 1) @(posedge baud_clk);
  endtask

  task automatic write_reg(input logic [3:0] addr, input logic [31:0] data,
                           output logic [1:0] resp);
    @(posedge baud_clk);
    #2;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    aw.addr = addr;
    w.data  = data;
    w.strb  = 4'hf;
    @(negedge baud_clk);
    while (!awready)
      @(negedge baud_clk);
    // W is taken on the same cycle as AW
    check_value("wready with awready", wready, 1'b1);
    @(posedge baud_clk);
    #2;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    while (!bvalid)
      @(negedge baud_clk);
    resp = b.resp;
  endtask

  task automatic read_reg(input logic [3:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    @(posedge baud_clk);
    #2;
    arvalid = 1'b1;
    ar.addr = addr;
    @(negedge baud_clk);
    while (!arready)
      @(negedge baud_clk);
    @(posedge baud_clk);
    #2;
    arvalid = 1'b0;
    while (!rvalid)
      @(negedge baud_clk);
    data = r.data;
    resp = r.resp;
  endtask

  // Builds the frame by rule and records the expected byte
  task automatic send_frame(input logic [7:0] data, input logic flip_par,
                            input logic flip_stop);
    logic                  par_bit;
    logic                  stop_bit;
    logic [10:0]           bits;
    uart_rx_pkg::rx_byte_t e;
    par_bit  = (par_odd ? ~^data : ^data) ^ flip_par;
    stop_bit = !flip_stop;
    bits     = {stop_bit, par_bit, data, 1'b0};
    for (int i = 0; i < uart_rx_pkg::FRAME_BITS; i++)
      drive_bit(bits[i]);
    // Bad stop bit leaves the line low, so give it an idle bit
    if (flip_stop)
      drive_bit(1'b1);
    e.data       = data;
    e.frame_err  = !stop_bit;
    // Parity bit is right by construction unless inverted on purpose
    e.parity_err = flip_par;
    if (rx_on)
    begin
      if (exp_q.size() < DEPTH)
        exp_q.push_back(e);
      else
        exp_overrun = 1'b1;
    end
  endtask

  function automatic logic [31:0] expected_status();
    logic [31:0] s;
    s       = '0;
    s[0]    = (exp_q.size() == 0);
    s[1]    = exp_overrun;
    s[11:8] = exp_q.size();
    return s;
  endfunction

  task automatic check_status();
    logic [31:0] d;
    logic [1:0]  resp;
    read_reg(uart_rx_pkg::REG_STATUS, d, resp);
    check_value("STATUS read", d, expected_status());
    check_value("STATUS resp", resp, uart_rx_pkg::RESP_OKAY);
  endtask

  // Pops DATA and compares with the model head
  task automatic read_byte();
    logic [31:0]           d;
    logic [1:0]            resp;
    uart_rx_pkg::rx_byte_t e;
    read_reg(uart_rx_pkg::REG_DATA, d, resp);
    check_value("DATA resp", resp, uart_rx_pkg::RESP_OKAY);
    if (exp_q.size() == 0)
      check_value("DATA empty read", d, 32'h8000_0000);
    else
    begin
      e = exp_q.pop_front();
      check_value("DATA read", d, {22'd0, e});
    end
  endtask

  task automatic wait_for_byte();
    logic [31:0] d;
    logic [1:0]  resp;
    int          polls;
    polls = 0;
    d     = 32'h1;
    while (d[0] && polls < 20)
    begin
      read_reg(uart_rx_pkg::REG_STATUS, d, resp);
      polls = polls + 1;
    end
    if (d[0])
    begin
      errors = errors + 1;
      $display("No received byte showed up in the FIFO after %0d polls", polls);
    end
  endtask

  task automatic set_ctrl(input logic odd, input logic en);
    logic [31:0] d;
    logic [1:0]  resp;
    write_reg(uart_rx_pkg::REG_CTRL, {30'd0, en, odd}, resp);
    check_value("CTRL write resp", resp, uart_rx_pkg::RESP_OKAY);
    par_odd = odd;
    rx_on   = en;
    read_reg(uart_rx_pkg::REG_CTRL, d, resp);
    check_value("CTRL read", d, {30'd0, en, odd});
  endtask

  initial
  begin
    logic [31:0] d;
    logic [1:0]  resp;
    baud_clk    = 1'b0;
    reset_n     = 1'b0;
    rx          = 1'b1;
    awvalid     = 1'b0;
    wvalid      = 1'b0;
    aw          = '0;
    w           = '0;
    bready      = 1'b1;
    arvalid     = 1'b0;
    ar          = '0;
    rready      = 1'b1;
    exp_overrun = 1'b0;
    par_odd     = 1'b0;
    rx_on       = 1'b1;
    seed        = 91;
    errors      = 0;
    cycle_cnt   = 0;
    repeat (4) @(posedge baud_clk);
    #2;
    reset_n = 1'b1;

    // Reset values
    check_status();
    read_reg(uart_rx_pkg::REG_CTRL, d, resp);
    check_value("CTRL after reset", d, 32'h2);
    read_byte();

    // Random bytes, even parity then odd
    repeat (40)
    begin
      send_frame($random(seed), 1'b0, 1'b0);
      wait_for_byte();
      read_byte();
    end
    set_ctrl(1'b1, 1'b1);
    repeat (4)
    begin
      send_frame($random(seed), 1'b0, 1'b0);
      wait_for_byte();
      read_byte();
    end

    // Deliberate parity and stop bit errors
    repeat (2)
    begin
      send_frame($random(seed), 1'b1, 1'b0);
      wait_for_byte();
      read_byte();
    end
    repeat (2)
    begin
      send_frame($random(seed), 1'b0, 1'b1);
      wait_for_byte();
      read_byte();
    end

    // Short low pulse is a glitch
    @(posedge baud_clk);
    #2;
    rx = 1'b0;
    repeat (3) @(posedge baud_clk);
    #2;
    rx = 1'b1;
    // Long enough for a falsely started frame to reach the FIFO
    repeat (uart_rx_pkg::FRAME_BITS * uart_rx_pkg::OVERSAMPLE + 30) @(posedge baud_clk);
    check_status();

    // Ten frames into an eight entry FIFO
    repeat (10)
      send_frame($random(seed), 1'b0, 1'b0);
    repeat (8) @(posedge baud_clk);
    check_status();
    write_reg(uart_rx_pkg::REG_STATUS, 32'h2, resp);
    check_value("STATUS write resp", resp, uart_rx_pkg::RESP_OKAY);
    exp_overrun = 1'b0;
    check_status();
    repeat (DEPTH)
      read_byte();
    check_status();

    // Bad accesses answer SLVERR
    write_reg(uart_rx_pkg::REG_DATA, 32'h55, resp);
    check_value("DATA write resp", resp, uart_rx_pkg::RESP_SLVERR);
    write_reg(4'hc, 32'h1, resp);
    check_value("0xC write resp", resp, uart_rx_pkg::RESP_SLVERR);
    read_reg(4'hc, d, resp);
    check_value("0xC read data", d, 32'h0);
    check_value("0xC read resp", resp, uart_rx_pkg::RESP_SLVERR);

    // Receiver disabled, frame is ignored
    set_ctrl(par_odd, 1'b0);
    send_frame($random(seed), 1'b0, 1'b0);
    repeat (20) @(posedge baud_clk);
    check_status();

    $display("Run complete with %0d errors", errors);
    if (errors == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

//--- uart_rx.f
hdl/uart_rx_pkg.sv
hdl/rx_sipo.sv
hdl/rx_deframe.sv
hdl/rx_fifo.sv
hdl/rx_axil_regs.sv
hdl/uart_rx_top.sv
testbench/uart_rx_tb.sv
